//--- design/monitor_pkg.sv
/*
 * Shared types for the UART debug monitor
 *   RAM word address, instruction and data words, byte enables
 *   CPU start address, host command codes
 *   ACK reply byte and the LED register address
 */
package monitor_pkg;

	// Word address, bits 11:2 of a byte address
	typedef logic [9:0] ram_adr_t;
	typedef logic [31:0] inst_word_t;
	typedef logic [31:0] data_word_t;
	typedef logic [3:0] byte_en_t;
	// Start address, bits 31:2
	typedef logic [29:0] start_adr_t;

	// Command bytes as ASCII
	typedef enum logic [7:0] {
		CMD_WR_INST = 8'h49,
		CMD_WR_DATA = 8'h44,
		CMD_RD_INST = 8'h52,
		CMD_RD_DATA = 8'h72,
		CMD_GO      = 8'h47,
		CMD_QUIT    = 8'h51
	} cmd_t;

	// 'K'
	localparam logic [7:0] ACK_BYTE = 8'h4B;

	// Top word of the data space
	localparam ram_adr_t LED_ADR = 10'h3FF;

endpackage

//--- design/uart_rx.sv
/*
 * 8N1 serial receiver
 *   two-flop synchronizer on the line
 *   bit-time counter sampling near mid-bit
 *   byte output with a one-cycle valid on a good stop bit
 */
`timescale 1ns/1ps

module uart_rx #(
	parameter int CLKS_PER_BIT = 868
) (
	input  logic       i_clk,
	input  logic       i_arst_n,
	input  logic       i_rx,
	output logic [7:0] o_rx_data,
	output logic       o_rx_valid
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] BIT_END = CNT_W'(CLKS_PER_BIT - 1);
	// Slightly early, the synchronizer adds two cycles
	localparam logic [CNT_W-1:0] HALF_END = CNT_W'(CLKS_PER_BIT / 2 - 2);

	typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_t;

	state_t state;
	logic [1:0] sync;
	logic [CNT_W-1:0] cnt;
	logic [2:0] bit_idx;
	logic [7:0] shreg;
	logic rx_s;

	assign rx_s = sync[1];

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			sync <= 2'b11;
			state <= S_IDLE;
			cnt <= '0;
			bit_idx <= '0;
			o_rx_valid <= 1'b0;
		end else begin
			sync <= {sync[0], i_rx};
			o_rx_valid <= 1'b0;
			case (state)
				S_IDLE: begin
					cnt <= '0;
					bit_idx <= '0;
					if (!rx_s) begin
						state <= S_START;
					end
				end
				S_START: begin
					cnt <= '0;
					if (cnt == HALF_END) begin
						// Glitch check on the start bit
						state <= rx_s ? S_IDLE : S_DATA;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				S_DATA: begin
					cnt <= (cnt == BIT_END) ? '0 : cnt + 1'b1;
					if (cnt == BIT_END) begin
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7) begin
							state <= S_STOP;
						end
					end
				end
				default: begin
					cnt <= cnt + 1'b1;
					if (cnt == BIT_END) begin
						o_rx_valid <= rx_s;
						state <= S_IDLE;
					end
				end
			endcase
		end
	end

	// LSB first
	always_ff @(posedge i_clk) begin
		if (state == S_DATA && cnt == BIT_END) begin
			shreg <= {rx_s, shreg[7:1]};
		end
	end

	assign o_rx_data = shreg;

endmodule

//--- design/uart_tx.sv
/*
 * 8N1 serial transmitter
 *   start strobe loads start, data and stop bits
 *   one bit per CLKS_PER_BIT cycles, busy for the whole frame
 */
`timescale 1ns/1ps

module uart_tx #(
	parameter int CLKS_PER_BIT = 868
) (
	input  logic       i_clk,
	input  logic       i_arst_n,
	input  logic       i_tx_start,
	input  logic [7:0] i_tx_data,
	output logic       o_tx,
	output logic       o_tx_busy
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] BIT_END = CNT_W'(CLKS_PER_BIT - 1);

	logic [9:0] shreg;
	logic [CNT_W-1:0] cnt;
	logic [3:0] bit_cnt;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			// Line idles high
			shreg <= '1;
			cnt <= '0;
			bit_cnt <= '0;
			o_tx_busy <= 1'b0;
		end else if (i_tx_start && !o_tx_busy) begin
			shreg <= {1'b1, i_tx_data, 1'b0};
			cnt <= '0;
			bit_cnt <= '0;
			o_tx_busy <= 1'b1;
		end else if (o_tx_busy) begin
			cnt <= (cnt == BIT_END) ? '0 : cnt + 1'b1;
			if (cnt == BIT_END) begin
				shreg <= {1'b1, shreg[9:1]};
				bit_cnt <= bit_cnt + 4'd1;
				// Stop bit done
				if (bit_cnt == 4'd9) begin
					o_tx_busy <= 1'b0;
				end
			end
		end
	end

	assign o_tx = shreg[0];

	// The sender has to wait for the frame to finish
	a_no_start_busy: assert property (
		@(posedge i_clk) disable iff (!i_arst_n) i_tx_start |-> !o_tx_busy
	);

endmodule

//--- design/monitor_cmd.sv
/*
 * Host command parser and sequencer
 *   decodes the command byte, collects address and data fields
 *   RAM write enables and the shared read address
 *   ACK or read-word reply, one byte per free transmitter
 *   CPU start address, start and quit strobes
 */
`timescale 1ns/1ps

module monitor_cmd (
	input  logic                    i_clk,
	input  logic                    i_arst_n,
	input  logic [7:0]              i_rx_data,
	input  logic                    i_rx_valid,
	input  logic                    i_tx_busy,
	input  monitor_pkg::inst_word_t i_i_ram_rdata,
	input  monitor_pkg::data_word_t i_d_ram_rdata,
	output logic [7:0]              o_tx_data,
	output logic                    o_tx_start,
	output monitor_pkg::ram_adr_t   o_ram_radr,
	output monitor_pkg::ram_adr_t   o_i_ram_wadr,
	output monitor_pkg::inst_word_t o_i_ram_wdata,
	output logic                    o_i_ram_wen,
	output monitor_pkg::ram_adr_t   o_d_ram_wadr,
	output monitor_pkg::data_word_t o_d_ram_wdata,
	output logic                    o_d_ram_wen,
	output monitor_pkg::start_adr_t o_start_adr,
	output logic                    o_cpu_start,
	output logic                    o_quit_cmd
);

	import monitor_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE, S_FIELD, S_WRITE, S_RD_WAIT, S_RD_LATCH, S_ACK, S_SEND
	} state_t;

	state_t state;
	cmd_t cmd;
	logic [2:0] byte_cnt;
	logic [2:0] last_idx;
	logic [15:0] adr_buf;
	logic [31:0] data_buf;
	logic [31:0] reply;
	logic is_write;

	assign is_write = (cmd == CMD_WR_INST) || (cmd == CMD_WR_DATA);
	// Writes take 2 address + 4 data bytes, others 2 address bytes
	assign last_idx = is_write ? 3'd5 : 3'd1;

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= S_IDLE;
			cmd <= CMD_QUIT;
			byte_cnt <= '0;
			o_start_adr <= '0;
			o_cpu_start <= 1'b0;
			o_quit_cmd <= 1'b0;
		end else begin
			o_cpu_start <= 1'b0;
			o_quit_cmd <= 1'b0;
			case (state)
				S_IDLE: begin
					byte_cnt <= '0;
					// Nothing is taken while a reply is on the line
					if (i_rx_valid && !i_tx_busy) begin
						case (i_rx_data)
							CMD_WR_INST, CMD_WR_DATA, CMD_RD_INST, CMD_RD_DATA, CMD_GO: begin
								cmd <= cmd_t'(i_rx_data);
								state <= S_FIELD;
							end
							CMD_QUIT: begin
								o_quit_cmd <= 1'b1;
								state <= S_ACK;
							end
							default: ;
						endcase
					end
				end
				S_FIELD: begin
					if (i_rx_valid) begin
						byte_cnt <= (byte_cnt == last_idx) ? 3'd0 : byte_cnt + 3'd1;
						if (byte_cnt == last_idx) begin
							case (cmd)
								CMD_GO: begin
									o_start_adr <= {14'd0, i_rx_data, adr_buf[15:8]};
									o_cpu_start <= 1'b1;
									state <= S_ACK;
								end
								CMD_RD_INST, CMD_RD_DATA: state <= S_RD_WAIT;
								default: state <= S_WRITE;
							endcase
						end
					end
				end
				S_WRITE: state <= S_ACK;
				S_RD_WAIT: state <= S_RD_LATCH;
				S_RD_LATCH: begin
					byte_cnt <= 3'd3;
					state <= S_SEND;
				end
				S_ACK: begin
					byte_cnt <= '0;
					state <= S_SEND;
				end
				default: begin
					if (!i_tx_busy) begin
						byte_cnt <= byte_cnt - 3'd1;
						if (byte_cnt == 3'd0) begin
							state <= S_IDLE;
						end
					end
				end
			endcase
		end
	end

	// Field bytes and reply word, LSB first
	always_ff @(posedge i_clk) begin
		if (state == S_FIELD && i_rx_valid) begin
			if (byte_cnt < 3'd2) begin
				adr_buf <= {i_rx_data, adr_buf[15:8]};
			end else begin
				data_buf <= {i_rx_data, data_buf[31:8]};
			end
		end
		case (state)
			S_ACK: reply <= {24'd0, ACK_BYTE};
			S_RD_LATCH: reply <= (cmd == CMD_RD_INST) ? i_i_ram_rdata : i_d_ram_rdata;
			S_SEND: begin
				if (!i_tx_busy) begin
					reply <= {8'd0, reply[31:8]};
				end
			end
			default: ;
		endcase
	end

	// Busy rises the next cycle, so S_SEND cannot start twice in a row
	assign o_tx_start = (state == S_SEND) && !i_tx_busy;
	assign o_tx_data = reply[7:0];

	assign o_ram_radr = adr_buf[9:0];
	assign o_i_ram_wadr = adr_buf[9:0];
	assign o_d_ram_wadr = adr_buf[9:0];
	assign o_i_ram_wdata = data_buf;
	assign o_d_ram_wdata = data_buf;
	assign o_i_ram_wen = (state == S_WRITE) && (cmd == CMD_WR_INST);
	assign o_d_ram_wen = (state == S_WRITE) && (cmd == CMD_WR_DATA);

	a_one_ram_wen: assert property (
		@(posedge i_clk) disable iff (!i_arst_n) !(o_i_ram_wen && o_d_ram_wen)
	);
	a_start_pulse: assert property (
		@(posedge i_clk) disable iff (!i_arst_n) o_cpu_start |=> !o_cpu_start
	);
	a_quit_pulse: assert property (
		@(posedge i_clk) disable iff (!i_arst_n) o_quit_cmd |=> !o_quit_cmd
	);

endmodule

//--- design/word_ram.sv
/*
 * Word RAM, one write and one read port
 *   word type set per instance
 *   registered read, one cycle latency
 */
`timescale 1ns/1ps

module word_ram #(
	parameter type word_t = monitor_pkg::data_word_t
) (
	input  logic                  i_clk,
	input  monitor_pkg::ram_adr_t i_wadr,
	input  monitor_pkg::ram_adr_t i_radr,
	input  word_t                 i_wdata,
	input  logic                  i_wen,
	output word_t                 o_rdata
);

	import monitor_pkg::*;

	localparam int DEPTH = 1 << $bits(ram_adr_t);

	word_t mem [DEPTH];

	// Read before write on the same address
	always_ff @(posedge i_clk) begin
		if (i_wen) begin
			mem[i_wadr] <= i_wdata;
		end
		o_rdata <= mem[i_radr];
	end

endmodule

//--- design/io_led.sv
/*
 * I/O store decoder for the RGB LED register
 *   byte 0 store to LED_ADR loads data bits 2:0
 */
`timescale 1ns/1ps

module io_led (
	input  logic                    i_clk,
	input  logic                    i_arst_n,
	input  monitor_pkg::ram_adr_t   i_st_adr_io,
	input  monitor_pkg::byte_en_t   i_st_we_io,
	input  monitor_pkg::data_word_t i_st_data_io,
	output logic [2:0]              o_rgb_led
);

	import monitor_pkg::*;

	logic led_sel;

	assign led_sel = (i_st_adr_io == LED_ADR) && i_st_we_io[0];

	always_ff @(posedge i_clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_rgb_led <= 3'd0;
		end else if (led_sel) begin
			o_rgb_led <= i_st_data_io[2:0];
		end
	end

	// CPU side may leave address and data floating when it is not storing
	a_idle_store: assert property (
		@(posedge i_clk) disable iff (!i_arst_n)
		$isunknown({i_st_adr_io, i_st_data_io}) |-> (i_st_we_io == '0)
	);

endmodule

//--- design/monitor_top.sv
/*
 * UART debug monitor top level
 *   receiver, command parser, transmitter
 *   instruction and data RAMs
 *   LED register on the CPU store port
 */
`timescale 1ns/1ps

module monitor_top #(
	parameter int CLKS_PER_BIT = 868
) (
	input  logic                    i_clk,
	input  logic                    i_arst_n,
	input  logic                    i_rx,
	input  monitor_pkg::ram_adr_t   i_st_adr_io,
	input  monitor_pkg::byte_en_t   i_st_we_io,
	input  monitor_pkg::data_word_t i_st_data_io,
	output logic                    o_tx,
	output logic [2:0]              o_rgb_led,
	output monitor_pkg::start_adr_t o_start_adr,
	output logic                    o_cpu_start,
	output logic                    o_quit_cmd
);

	import monitor_pkg::*;

	logic [7:0] rx_data;
	logic rx_valid;
	logic [7:0] tx_data;
	logic tx_start;
	logic tx_busy;
	ram_adr_t ram_radr;
	ram_adr_t inst_wadr;
	ram_adr_t data_wadr;
	inst_word_t inst_wdata;
	inst_word_t inst_rdata;
	data_word_t data_wdata;
	data_word_t data_rdata;
	logic inst_wen;
	logic data_wen;

	uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_rx_inst (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_rx(i_rx),
		.o_rx_data(rx_data),
		.o_rx_valid(rx_valid)
	);

	monitor_cmd monitor_cmd_inst (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_rx_data(rx_data),
		.i_rx_valid(rx_valid),
		.i_tx_busy(tx_busy),
		.i_i_ram_rdata(inst_rdata),
		.i_d_ram_rdata(data_rdata),
		.o_tx_data(tx_data),
		.o_tx_start(tx_start),
		.o_ram_radr(ram_radr),
		.o_i_ram_wadr(inst_wadr),
		.o_i_ram_wdata(inst_wdata),
		.o_i_ram_wen(inst_wen),
		.o_d_ram_wadr(data_wadr),
		.o_d_ram_wdata(data_wdata),
		.o_d_ram_wen(data_wen),
		.o_start_adr(o_start_adr),
		.o_cpu_start(o_cpu_start),
		.o_quit_cmd(o_quit_cmd)
	);

	word_ram #(.word_t(inst_word_t)) inst_ram (
		.i_clk(i_clk),
		.i_wadr(inst_wadr),
		.i_radr(ram_radr),
		.i_wdata(inst_wdata),
		.i_wen(inst_wen),
		.o_rdata(inst_rdata)
	);

	word_ram #(.word_t(data_word_t)) data_ram (
		.i_clk(i_clk),
		.i_wadr(data_wadr),
		.i_radr(ram_radr),
		.i_wdata(data_wdata),
		.i_wen(data_wen),
		.o_rdata(data_rdata)
	);

	uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) uart_tx_inst (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_tx_start(tx_start),
		.i_tx_data(tx_data),
		.o_tx(o_tx),
		.o_tx_busy(tx_busy)
	);

	io_led io_led_inst (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_st_adr_io(i_st_adr_io),
		.i_st_we_io(i_st_we_io),
		.i_st_data_io(i_st_data_io),
		.o_rgb_led(o_rgb_led)
	);

endmodule

//--- bench/tb_monitor_top.sv
/*
 * Directed testbench for the UART debug monitor
 *   8N1 host model at 4 clocks per bit
 *   RAM model for expected read words, pulse counters for start and quit
 *   six tests: RAM write and read, RAM separation, go, quit, LED store,
 *   unknown command
 */
`timescale 1ns/1ps

module tb_monitor_top;

	import monitor_pkg::*;

	localparam int CLKS_PER_BIT = 4;
	localparam int DRIVE_DLY = 2;
	localparam int REPLY_WAIT = 8 * CLKS_PER_BIT;
	localparam int N_ADR = 3;
	// Serial frames per test with silent waits counted as frames
	localparam int FRAMES = 15 + N_ADR * 2 * 15 + 4 + 2 + 1 + 10;
	localparam int CYCLE_LIMIT = 2 * FRAMES * 10 * CLKS_PER_BIT;

	logic i_clk;
	logic i_arst_n;
	logic i_rx;
	ram_adr_t i_st_adr_io;
	byte_en_t i_st_we_io;
	data_word_t i_st_data_io;
	logic o_tx;
	logic [2:0] o_rgb_led;
	start_adr_t o_start_adr;
	logic o_cpu_start;
	logic o_quit_cmd;

	integer seed;
	int err_cnt;
	int cycle_cnt;
	int start_pulses;
	int quit_pulses;
	time start_pulse_time;
	time start_bit_time;
	ram_adr_t sep_adr;
	data_word_t inst_model [1024];
	data_word_t data_model [1024];

	monitor_top #(.CLKS_PER_BIT(CLKS_PER_BIT)) monitor_top_inst (
		.i_clk(i_clk),
		.i_arst_n(i_arst_n),
		.i_rx(i_rx),
		.i_st_adr_io(i_st_adr_io),
		.i_st_we_io(i_st_we_io),
		.i_st_data_io(i_st_data_io),
		.o_tx(o_tx),
		.o_rgb_led(o_rgb_led),
		.o_start_adr(o_start_adr),
		.o_cpu_start(o_cpu_start),
		.o_quit_cmd(o_quit_cmd)
	);

	initial begin
		i_clk = 1'b0;
		forever #20 i_clk = ~i_clk;
	end

	// Strobe counters sampled away from the active edge
	always @(negedge i_clk) begin
		if (o_cpu_start === 1'b1) begin
			start_pulses++;
			start_pulse_time = $time;
		end
		if (o_quit_cmd === 1'b1) begin
			quit_pulses++;
		end
	end

	task automatic check_word(input data_word_t got, input data_word_t exp, input string what);
		if (got !== exp) begin
			err_cnt++;
			$display("[ERROR] %0t: %s read %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_ack(input logic [7:0] got, input string what);
		if (got !== ACK_BYTE) begin
			err_cnt++;
			$display("[ERROR] %0t: %s reply %h, expected %h", $time, what, got, ACK_BYTE);
		end
	endtask

	task automatic check_start_adr(input start_adr_t got, input start_adr_t exp, input string what);
		if (got !== exp) begin
			err_cnt++;
			$display("[ERROR] %0t: %s start address %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_led(input logic [2:0] got, input logic [2:0] exp, input string what);
		if (got !== exp) begin
			err_cnt++;
			$display("[ERROR] %0t: %s LED %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_pulses(input int got, input int exp, input string what);
		if (got != exp) begin
			err_cnt++;
			$display("[ERROR] %0t: %s pulse count %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	// Start bit, 8 data bits LSB first, stop bit
	task automatic send_byte(input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge i_clk);
			#DRIVE_DLY i_rx = frame[i];
			repeat (CLKS_PER_BIT - 1) @(posedge i_clk);
		end
	endtask

	task automatic recv_byte(output logic [7:0] b);
		int wait_cnt;
		wait_cnt = 0;
		b = 8'hxx;
		@(negedge i_clk);
		while (o_tx !== 1'b0 && wait_cnt < REPLY_WAIT) begin
			@(negedge i_clk);
			wait_cnt++;
		end
		if (o_tx !== 1'b0) begin
			err_cnt++;
			$display("No start bit from the DUT within %0d cycles, at time %0t",
				REPLY_WAIT, $time);
		end else begin
			start_bit_time = $time;
			// Move to the middle of the start bit
			repeat (CLKS_PER_BIT / 2) @(negedge i_clk);
			if (o_tx !== 1'b0) begin
				err_cnt++;
				$display("Start bit from the DUT too short, at time %0t", $time);
			end
			for (int i = 0; i < 8; i++) begin
				repeat (CLKS_PER_BIT) @(negedge i_clk);
				b[i] = o_tx;
			end
			repeat (CLKS_PER_BIT) @(negedge i_clk);
			if (o_tx !== 1'b1) begin
				err_cnt++;
				$display("Missing stop bit from the DUT, at time %0t", $time);
			end
		end
	endtask

	task automatic send_adr(input ram_adr_t adr);
		send_byte(adr[7:0]);
		send_byte({6'd0, adr[9:8]});
	endtask

	task automatic write_word(input cmd_t cmd, input ram_adr_t adr, input data_word_t w);
		logic [7:0] b;
		send_byte(cmd);
		send_adr(adr);
		for (int i = 0; i < 4; i++) begin
			send_byte(w[8*i +: 8]);
		end
		recv_byte(b);
		check_ack(b, cmd == CMD_WR_INST ? "instruction write" : "data write");
		if (cmd == CMD_WR_INST) begin
			inst_model[adr] = w;
		end else begin
			data_model[adr] = w;
		end
	endtask

	task automatic read_word(input cmd_t cmd, input ram_adr_t adr, output data_word_t w);
		logic [7:0] b;
		send_byte(cmd);
		send_adr(adr);
		for (int i = 0; i < 4; i++) begin
			recv_byte(b);
			w[8*i +: 8] = b;
		end
	endtask

	task automatic store_io(input ram_adr_t adr, input byte_en_t be, input data_word_t d);
		@(posedge i_clk);
		#DRIVE_DLY;
		i_st_adr_io = adr;
		i_st_we_io = be;
		i_st_data_io = d;
		@(posedge i_clk);
		#DRIVE_DLY;
		i_st_adr_io = '0;
		i_st_we_io = '0;
		i_st_data_io = '0;
		@(negedge i_clk);
	endtask

	task automatic test_inst_write_read();
		ram_adr_t adr;
		data_word_t w;
		data_word_t got;
		w = $random(seed);
		adr = ram_adr_t'($random(seed));
		write_word(CMD_WR_INST, adr, w);
		read_word(CMD_RD_INST, adr, got);
		check_word(got, inst_model[adr], "instruction RAM");
	endtask

	// Same addresses in both RAMs and all written before any read
	task automatic test_ram_separation();
		ram_adr_t base;
		data_word_t w;
		data_word_t got;
		base = ram_adr_t'($random(seed));
		for (int i = 0; i < N_ADR; i++) begin
			w = $random(seed);
			write_word(CMD_WR_INST, base + ram_adr_t'(i), w);
			write_word(CMD_WR_DATA, base + ram_adr_t'(i), ~w);
		end
		for (int i = 0; i < N_ADR; i++) begin
			read_word(CMD_RD_INST, base + ram_adr_t'(i), got);
			check_word(got, inst_model[base + ram_adr_t'(i)], "separate instruction RAM");
			read_word(CMD_RD_DATA, base + ram_adr_t'(i), got);
			check_word(got, data_model[base + ram_adr_t'(i)], "separate data RAM");
		end
		sep_adr = base;
	endtask

	task automatic test_go();
		logic [15:0] a;
		logic [7:0] b;
		a = 16'($random(seed));
		start_pulses = 0;
		quit_pulses = 0;
		send_byte(CMD_GO);
		send_byte(a[7:0]);
		send_byte(a[15:8]);
		recv_byte(b);
		check_ack(b, "go");
		check_start_adr(o_start_adr, {14'd0, a}, "go");
		check_pulses(start_pulses, 1, "CPU start");
		check_pulses(quit_pulses, 0, "quit during go");
		if (start_pulses == 1 && start_pulse_time >= start_bit_time) begin
			err_cnt++;
			$display("[ERROR] %0t: CPU start pulse came after the ACK start bit", $time);
		end
	endtask

	task automatic test_quit();
		logic [7:0] b;
		start_pulses = 0;
		quit_pulses = 0;
		send_byte(CMD_QUIT);
		recv_byte(b);
		check_ack(b, "quit");
		check_pulses(quit_pulses, 1, "quit");
		check_pulses(start_pulses, 0, "CPU start during quit");
	endtask

	task automatic test_led_store();
		data_word_t d;
		logic [2:0] led_exp;
		d = $random(seed);
		// Nonzero low bits so the first store differs from the reset value
		if (d[2:0] == 3'd0) begin
			d[2:0] = 3'd5;
		end
		store_io(LED_ADR, 4'b0001, d);
		led_exp = d[2:0];
		check_led(o_rgb_led, led_exp, "byte 0 store to LED address");
		// Low bits differ from the register so a wrong update shows
		d = $random(seed);
		d[2:0] = ~led_exp;
		store_io(LED_ADR - 10'd1, 4'b0001, d);
		check_led(o_rgb_led, led_exp, "store to other address");
		store_io(LED_ADR, 4'b0010, d);
		check_led(o_rgb_led, led_exp, "byte 1 store to LED address");
	endtask

	task automatic test_unknown_cmd();
		data_word_t got;
		send_byte(8'h5A);
		for (int i = 0; i < 20 * CLKS_PER_BIT; i++) begin
			@(negedge i_clk);
			if (o_tx !== 1'b1) begin
				err_cnt++;
				$display("[ERROR] %0t: reply to an unknown command byte", $time);
				break;
			end
		end
		read_word(CMD_RD_DATA, sep_adr, got);
		check_word(got, data_model[sep_adr], "data RAM after unknown command");
	endtask

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < CYCLE_LIMIT) begin
			@(posedge i_clk);
			cycle_cnt++;
		end
		$display("Run stopped after the limit of %0d cycles, %0d errors", CYCLE_LIMIT, err_cnt);
		$display("Finished with errors");
		$finish;
	end

	initial begin
		seed = 32'h419d;
		err_cnt = 0;
		start_pulses = 0;
		quit_pulses = 0;
		start_pulse_time = 0;
		start_bit_time = 0;
		sep_adr = '0;
		i_arst_n = 1'b0;
		i_rx = 1'b1;
		i_st_adr_io = '0;
		i_st_we_io = '0;
		i_st_data_io = '0;
		repeat (5) @(posedge i_clk);
		#DRIVE_DLY i_arst_n = 1'b1;
		@(negedge i_clk);
		if (o_tx !== 1'b1 || o_cpu_start !== 1'b0 || o_quit_cmd !== 1'b0) begin
			err_cnt++;
			$display("[ERROR] %0t: serial line or strobes wrong after reset", $time);
		end
		check_start_adr(o_start_adr, '0, "after reset");
		check_led(o_rgb_led, 3'd0, "after reset");

		test_inst_write_read();
		test_ram_separation();
		test_go();
		test_quit();
		test_led_store();
		test_unknown_cmd();

		$display("Tests done, %0d errors", err_cnt);
		if (err_cnt == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- sources.f
design/monitor_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/monitor_cmd.sv
design/word_ram.sv
design/io_led.sv
design/monitor_top.sv
bench/tb_monitor_top.sv
